/* emesh_pkg.sv */
package emesh_pkg;

   //##################################################
   // Bus widths
   //##################################################
   localparam int AW         = 32;                // Address width
   localparam int DW         = 32;                // Data width
   localparam int PW         = 104;               // eMesh packet width
   localparam int ID_W       = 12;                // Chip ID, top address bits
   localparam int DATAMODE_W = 2;
   localparam int CTRLMODE_W = 5;

   //##################################################
   // Packet layout, bottom up
   //##################################################
   localparam int PKT_WRITE        = 0;           // Write flag
   localparam int PKT_DATAMODE_LSB = 1;           // Bits 2:1
   localparam int PKT_CTRLMODE_LSB = 3;           // Bits 7:3
   localparam int PKT_DSTADDR_LSB  = 8;           // Bits 39:8
   localparam int PKT_DATA_LSB     = 40;          // Bits 71:40
   localparam int PKT_SRCADDR_LSB  = 72;          // Bits 103:72

   localparam logic [DATAMODE_W-1:0] DATAMODE_WORD = 2'b10; // 32 bit access

   //##################################################
   // IDs, burst and memory sizing
   //##################################################
   localparam logic [ID_W-1:0] ELINK_ID = 12'h810; // Own link ID, register space
   localparam int N_TRANS   = 8;                  // Transactions per burst
   localparam int MEM_DEPTH = 16;                 // Words in memory model
   localparam int MEM_AW    = $clog2(MEM_DEPTH);  // Word index width, addr 5:2

   typedef logic [PW-1:0]                 packet_t;
   typedef logic [AW-1:0]                 addr_t;
   typedef logic [DW-1:0]                 data_t;
   typedef logic [ID_W-1:0]               chip_id_t;
   typedef logic [$clog2(N_TRANS)-1:0]    idx_t;  // 0 .. N_TRANS-1

   // Generator phases
   typedef enum logic [1:0] {
      IDLE,
      WRITE,
      READ,
      DONE
   } gen_state_t;

endpackage

/* egen_fsm.sv */
`timescale 1ns/10ps

module egen_fsm (
   input  logic                  sys_clk,
   input  logic                  reset,
   input  logic                  start,        // One cycle pulse
   input  logic                  xfer,         // Accepted transfer this cycle
   input  logic                  last,         // Counter at final index
   output emesh_pkg::gen_state_t phase,
   output logic                  cnt_clear,
   output logic                  cnt_advance,
   output logic                  done
);

   emesh_pkg::gen_state_t state;
   emesh_pkg::gen_state_t state_nxt;
   logic                  go;                  // Start taken in IDLE
   logic                  burst_end;           // Final transfer of a burst

   assign go        = (state == emesh_pkg::IDLE) && start; // Start elsewhere ignored
   assign burst_end = xfer && last;

   //##################################################
   // Next state
   //##################################################
   always_comb begin
      state_nxt = state;
      case (state)
         emesh_pkg::IDLE:  if (go) state_nxt = emesh_pkg::WRITE;
         emesh_pkg::WRITE: if (burst_end) state_nxt = emesh_pkg::READ;
         emesh_pkg::READ:  if (burst_end) state_nxt = emesh_pkg::DONE;
         emesh_pkg::DONE:  state_nxt = emesh_pkg::IDLE;
         default:          state_nxt = emesh_pkg::IDLE;
      endcase
   end

   always_ff @(posedge sys_clk) begin
      if (reset) begin
         state <= emesh_pkg::IDLE;
         done  <= 1'b0;
      end else begin
         state <= state_nxt;
         done  <= (state == emesh_pkg::DONE); // Pulse while leaving DONE
      end
   end

   // Counter control, clear on each phase entry
   assign cnt_clear   = go || burst_end;
   assign cnt_advance = xfer;
   assign phase       = state;

   //##################################################
   // Checks
   //##################################################
   a_done_pulse : assert property (
      @(posedge sys_clk) disable iff (reset)
      done |=> !done
   ) else $error("done held for more than one cycle");

endmodule

/* egen_counter.sv */
`timescale 1ns/10ps

module egen_counter (
   input  logic            sys_clk,
   input  logic            reset,
   input  logic            cnt_clear,    // Wins over advance
   input  logic            cnt_advance,
   output emesh_pkg::idx_t idx,
   output logic            last
);

   emesh_pkg::idx_t idx_q;

   always_ff @(posedge sys_clk) begin
      if (reset) begin
         idx_q <= '0;
      end else if (cnt_clear) begin
         idx_q <= '0;                           // Phase entry
      end else if (cnt_advance) begin
         idx_q <= idx_q + 1'b1;                 // One per accepted transfer
      end
   end

   assign idx  = idx_q;
   assign last = (idx_q == emesh_pkg::idx_t'(emesh_pkg::N_TRANS - 1));

   // FSM must clear on the final transfer, no wrap into a new burst
   a_no_overrun : assert property (
      @(posedge sys_clk) disable iff (reset)
      (cnt_advance && last) |-> cnt_clear
   ) else $error("burst counter advanced past last index");

endmodule

/* egen_datapath.sv */
`timescale 1ns/10ps

module egen_datapath (
   input  logic                  sys_clk,
   input  logic                  reset,
   input  emesh_pkg::gen_state_t phase,
   input  emesh_pkg::idx_t       idx,
   input  emesh_pkg::chip_id_t   dst_id,
   input  emesh_pkg::data_t      data_seed,
   input  logic                  wr_wait,
   input  logic                  rd_wait,
   output logic                  wr_access,
   output emesh_pkg::packet_t    wr_packet,
   output logic                  rd_access,
   output emesh_pkg::packet_t    rd_packet,
   output logic                  xfer
);

   logic            wr_xfer;
   logic            rd_xfer;
   logic            wr_load;                    // Present next write packet
   logic            rd_load;                    // Present next read packet
   logic            last;                       // Final index of the burst
   emesh_pkg::idx_t load_idx;

   // Packet for index i, write or read flavour
   function automatic emesh_pkg::packet_t make_packet(input logic write,
                                                      input emesh_pkg::idx_t i);
      emesh_pkg::packet_t pkt;
      emesh_pkg::addr_t   offset;
      offset = emesh_pkg::addr_t'(i) << 2;      // Word address i*4
      pkt = '0;                                 // ctrlmode stays zero
      pkt[emesh_pkg::PKT_WRITE] = write;
      pkt[emesh_pkg::PKT_DATAMODE_LSB +: emesh_pkg::DATAMODE_W] = emesh_pkg::DATAMODE_WORD;
      pkt[emesh_pkg::PKT_DSTADDR_LSB +: emesh_pkg::AW] =
         {dst_id, offset[emesh_pkg::AW-emesh_pkg::ID_W-1:0]};
      pkt[emesh_pkg::PKT_DATA_LSB +: emesh_pkg::DW] =
         write ? data_seed + emesh_pkg::data_t'(i) : '0;  // Read data is zero
      pkt[emesh_pkg::PKT_SRCADDR_LSB +: emesh_pkg::AW] =
         {emesh_pkg::ELINK_ID, offset[emesh_pkg::AW-emesh_pkg::ID_W-1:0]}; // Return addr
      return pkt;
   endfunction

   assign wr_xfer = wr_access && !wr_wait;
   assign rd_xfer = rd_access && !rd_wait;
   assign xfer    = wr_xfer || rd_xfer;
   assign last    = (idx == emesh_pkg::idx_t'(emesh_pkg::N_TRANS - 1));

   // First packet of a phase, or the one after an accepted non-final packet
   assign wr_load  = (phase == emesh_pkg::WRITE) && (!wr_access || (wr_xfer && !last));
   assign rd_load  = (phase == emesh_pkg::READ)  && (!rd_access || (rd_xfer && !last));
   assign load_idx = (wr_access || rd_access) ? idx + 1'b1 : idx; // Counter moves same edge

   //##################################################
   // Access flags
   //##################################################
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         wr_access <= 1'b0;
         rd_access <= 1'b0;
      end else begin
         if (wr_xfer && last) wr_access <= 1'b0;  // Burst finished
         else if (wr_load) wr_access <= 1'b1;
         if (rd_xfer && last) rd_access <= 1'b0;
         else if (rd_load) rd_access <= 1'b1;
      end
   end

   // Payload, held while wait is high
   always_ff @(posedge sys_clk) begin
      if (wr_load) wr_packet <= make_packet(1'b1, load_idx);
      if (rd_load) rd_packet <= make_packet(1'b0, load_idx);
   end

   //##################################################
   // Checks
   //##################################################
   a_wr_hold : assert property (
      @(posedge sys_clk) disable iff (reset)
      (wr_access && wr_wait) |=> (wr_access && $stable(wr_packet))
   ) else $error("write packet changed under wait");

   a_rd_hold : assert property (
      @(posedge sys_clk) disable iff (reset)
      (rd_access && rd_wait) |=> (rd_access && $stable(rd_packet))
   ) else $error("read packet changed under wait");

   a_one_stream : assert property (
      @(posedge sys_clk) disable iff (reset)
      !(wr_access && rd_access)
   ) else $error("write and read issued together");

endmodule

/* emesh_memory.sv */
`timescale 1ns/10ps

module emesh_memory (
   input  logic               sys_clk,
   input  logic               reset,
   input  logic               wr_access,
   input  emesh_pkg::packet_t wr_packet,
   input  logic               rd_access,
   input  emesh_pkg::packet_t rd_packet,
   input  logic               rr_wait,
   output logic               wr_wait,
   output logic               rd_wait,
   output logic               rr_access,
   output emesh_pkg::packet_t rr_packet
);

   emesh_pkg::data_t             mem [emesh_pkg::MEM_DEPTH];
   emesh_pkg::addr_t             wr_dst;
   emesh_pkg::data_t             wr_data;
   emesh_pkg::addr_t             rd_dst;
   emesh_pkg::addr_t             rd_src;
   logic [emesh_pkg::MEM_AW-1:0] wr_index;
   logic [emesh_pkg::MEM_AW-1:0] rd_index;
   logic                         wr_mem;       // Write to memory space
   logic                         rd_take;      // Read accepted this cycle
   logic                         rd_mem;       // Accepted read to memory space

   //##################################################
   // Field decode
   //##################################################
   assign wr_dst   = wr_packet[emesh_pkg::PKT_DSTADDR_LSB +: emesh_pkg::AW];
   assign wr_data  = wr_packet[emesh_pkg::PKT_DATA_LSB +: emesh_pkg::DW];
   assign rd_dst   = rd_packet[emesh_pkg::PKT_DSTADDR_LSB +: emesh_pkg::AW];
   assign rd_src   = rd_packet[emesh_pkg::PKT_SRCADDR_LSB +: emesh_pkg::AW];
   assign wr_index = wr_dst[emesh_pkg::MEM_AW+1:2];   // Word address
   assign rd_index = rd_dst[emesh_pkg::MEM_AW+1:2];

   // Own ID is register space, accepted but dropped
   assign wr_mem = wr_access &&
                   (wr_dst[emesh_pkg::AW-1 -: emesh_pkg::ID_W] != emesh_pkg::ELINK_ID);

   // Handshake
   assign wr_wait = 1'b0;                              // Writes never stall
   assign rd_wait = (rr_access && rr_wait) || wr_access; // Write wins, full response slot
   assign rd_take = rd_access && !rd_wait;
   assign rd_mem  = rd_take &&
                    (rd_dst[emesh_pkg::AW-1 -: emesh_pkg::ID_W] != emesh_pkg::ELINK_ID);

   //##################################################
   // Storage
   //##################################################
   always_ff @(posedge sys_clk) begin
      if (wr_mem) mem[wr_index] <= wr_data;
   end

   // Response slot valid
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         rr_access <= 1'b0;
      end else if (rd_mem) begin
         rr_access <= 1'b1;                    // Slot is free or drains now
      end else if (!rr_wait) begin
         rr_access <= 1'b0;                    // Accepted
      end
   end

   // Response payload, swapped addresses
   always_ff @(posedge sys_clk) begin
      if (rd_mem) begin
         rr_packet[emesh_pkg::PKT_WRITE] <= 1'b1;   // Response goes out as write
         rr_packet[emesh_pkg::PKT_DATAMODE_LSB +: emesh_pkg::DATAMODE_W] <=
            rd_packet[emesh_pkg::PKT_DATAMODE_LSB +: emesh_pkg::DATAMODE_W];
         rr_packet[emesh_pkg::PKT_CTRLMODE_LSB +: emesh_pkg::CTRLMODE_W] <=
            rd_packet[emesh_pkg::PKT_CTRLMODE_LSB +: emesh_pkg::CTRLMODE_W];
         rr_packet[emesh_pkg::PKT_DSTADDR_LSB +: emesh_pkg::AW] <= rd_src; // Back to sender
         rr_packet[emesh_pkg::PKT_DATA_LSB +: emesh_pkg::DW]    <= mem[rd_index];
         rr_packet[emesh_pkg::PKT_SRCADDR_LSB +: emesh_pkg::AW] <= rd_dst;
      end
   end

   //##################################################
   // Checks
   //##################################################
   a_rr_hold : assert property (
      @(posedge sys_clk) disable iff (reset)
      (rr_access && rr_wait) |=> (rr_access && $stable(rr_packet))
   ) else $error("read response changed under rr_wait");

endmodule

/* emesh_example.sv */
`timescale 1ns/10ps

module emesh_example (
   input  logic                sys_clk,
   input  logic                reset,
   input  logic                start,       // Kick off one write/read run
   input  emesh_pkg::chip_id_t dst_id,      // Held during a run
   input  emesh_pkg::data_t    data_seed,
   input  logic                rr_wait,     // Back-pressure on responses
   output logic                done,
   output logic                rr_access,
   output emesh_pkg::packet_t  rr_packet
);

   // Generator control
   emesh_pkg::gen_state_t phase;
   emesh_pkg::idx_t       idx;
   logic                  last;
   logic                  xfer;
   logic                  cnt_clear;
   logic                  cnt_advance;

   // Looped-back eMesh streams
   logic                  wr_access;
   emesh_pkg::packet_t    wr_packet;
   logic                  wr_wait;
   logic                  rd_access;
   emesh_pkg::packet_t    rd_packet;
   logic                  rd_wait;

   //##################################################
   // Transaction generator
   //##################################################
   egen_fsm u_fsm (
      .sys_clk     (sys_clk),
      .reset       (reset),
      .start       (start),
      .xfer        (xfer),
      .last        (last),
      .phase       (phase),
      .cnt_clear   (cnt_clear),
      .cnt_advance (cnt_advance),
      .done        (done)
   );

   egen_counter u_counter (
      .sys_clk     (sys_clk),
      .reset       (reset),
      .cnt_clear   (cnt_clear),
      .cnt_advance (cnt_advance),
      .idx         (idx),
      .last        (last)
   );

   egen_datapath u_datapath (
      .sys_clk   (sys_clk),
      .reset     (reset),
      .phase     (phase),
      .idx       (idx),
      .dst_id    (dst_id),
      .data_seed (data_seed),
      .wr_wait   (wr_wait),
      .rd_wait   (rd_wait),
      .wr_access (wr_access),
      .wr_packet (wr_packet),
      .rd_access (rd_access),
      .rd_packet (rd_packet),
      .xfer      (xfer)
   );

   //##################################################
   // Memory model
   //##################################################
   emesh_memory u_memory (
      .sys_clk   (sys_clk),
      .reset     (reset),
      .wr_access (wr_access),
      .wr_packet (wr_packet),
      .rd_access (rd_access),
      .rd_packet (rd_packet),
      .rr_wait   (rr_wait),
      .wr_wait   (wr_wait),
      .rd_wait   (rd_wait),
      .rr_access (rr_access),
      .rr_packet (rr_packet)
   );

endmodule

/* tb_emesh_example.sv */
`timescale 1ns/10ps

module tb_emesh_example;

   localparam int N_ROWS     = 6;
   localparam int MAX_CYCLES = N_ROWS * 200;    // Per-row budget, stalls included

   logic                sys_clk;
   logic                reset;
   logic                start;
   emesh_pkg::chip_id_t dst_id;
   emesh_pkg::data_t    data_seed;
   logic                rr_wait;
   logic                done;
   logic                rr_access;
   emesh_pkg::packet_t  rr_packet;

   logic                stall_en;               // Random rr_wait on/off
   int                  cycles = 0;
   int                  mismatches = 0;
   int                  other_errors = 0;
   int                  done_count = 0;
   logic                held = 1'b0;            // Response stalled last cycle
   emesh_pkg::packet_t  held_packet;
   emesh_pkg::packet_t  rx_q [$];               // Accepted responses, current row
   emesh_pkg::data_t    ref_mem [emesh_pkg::MEM_DEPTH];

   //##################################################
   // Stimulus table
   //##################################################
   string               row_name  [N_ROWS] = '{"plain_a", "plain_b", "overwrite",
                                               "elink_drop", "after_drop", "stalled"};
   emesh_pkg::chip_id_t row_dst   [N_ROWS] = '{12'h800, 12'h820, 12'h820,
                                               emesh_pkg::ELINK_ID, 12'h820, 12'h840};
   emesh_pkg::data_t    row_seed  [N_ROWS] = '{32'h1000_0000, 32'h2000_0100, 32'h3a5a_0000,
                                               32'hdead_0000, 32'h3a5a_0000, 32'h5555_aaaa};
   logic                row_stall [N_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
   int                  row_count [N_ROWS] = '{8, 8, 8, 0, 8, 8}; // Own ID gives none

   emesh_example uut (
      .sys_clk   (sys_clk),
      .reset     (reset),
      .start     (start),
      .dst_id    (dst_id),
      .data_seed (data_seed),
      .rr_wait   (rr_wait),
      .done      (done),
      .rr_access (rr_access),
      .rr_packet (rr_packet)
   );

   initial begin
      sys_clk = 1'b0;
      forever #20 sys_clk = ~sys_clk;           // 40 ns period
   end

   // Response the memory owes for read i of a run
   function automatic emesh_pkg::packet_t expect_response(input emesh_pkg::chip_id_t dst,
                                                          input int i,
                                                          input emesh_pkg::data_t d);
      return {dst, 20'(i * 4), d, emesh_pkg::ELINK_ID, 20'(i * 4),
              5'b0, emesh_pkg::DATAMODE_WORD, 1'b1};
   endfunction

   task automatic check_packet(input string name, input emesh_pkg::packet_t expected,
                               input emesh_pkg::packet_t actual);
      if (actual !== expected) begin
         mismatches++;
         $display("Mismatch %s: expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic check_data(input string name, input emesh_pkg::data_t expected,
                             input emesh_pkg::data_t actual);
      if (actual !== expected) begin
         mismatches++;
         $display("Mismatch %s: expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic check_count(input string name, input int expected, input int actual);
      if (actual != expected) begin
         mismatches++;
         $display("Mismatch %s: expected %0d actual %0d", name, expected, actual);
      end
   endtask

   //##################################################
   // Stall driver, monitor, timeout
   //##################################################
   always @(posedge sys_clk) begin
      rr_wait <= stall_en ? 1'($urandom % 2) : 1'b0;
   end

   always @(negedge sys_clk) begin
      if (!reset) begin
         if (held && (!rr_access || rr_packet !== held_packet)) begin
            other_errors++;
            $display("Read response dropped or changed while rr_wait was high");
         end
         if (rr_access && !rr_wait) rx_q.push_back(rr_packet); // Taken next edge
         if (done) done_count++;
         held        = rr_access && rr_wait;
         held_packet = rr_packet;
      end
   end

   always @(posedge sys_clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, a run never finished", cycles);
         $display("=== FAIL ===");
         $finish;
      end
   end

   //##################################################
   // Main sequence
   //##################################################
   initial begin
      int                 r;
      int                 i;
      int                 done_before;
      string              tname;
      emesh_pkg::packet_t rx;
      void'($urandom(32'ha3de_c0ee));
      reset     = 1'b1;
      start     = 1'b0;
      dst_id    = '0;
      data_seed = '0;
      rr_wait   = 1'b0;
      stall_en  = 1'b0;
      repeat (4) @(posedge sys_clk);
      reset <= 1'b0;
      repeat (3) begin                          // Quiet until start
         @(negedge sys_clk);
         if (rr_access || done) begin
            other_errors++;
            $display("rr_access or done went high after reset without a start");
         end
      end
      for (r = 0; r < N_ROWS; r++) begin
         @(posedge sys_clk);
         dst_id    <= row_dst[r];
         data_seed <= row_seed[r];
         stall_en  <= row_stall[r];
         start     <= 1'b1;
         rx_q.delete();
         done_before = done_count;
         if (row_dst[r] != emesh_pkg::ELINK_ID) begin
            for (i = 0; i < emesh_pkg::N_TRANS; i++) ref_mem[i] = row_seed[r] + i;
         end
         @(posedge sys_clk);
         start <= 1'b0;
         repeat (10) @(posedge sys_clk);
         start <= 1'b1;                         // Start during reads, no restart
         @(posedge sys_clk);
         start <= 1'b0;
         wait (done_count != done_before);
         @(posedge sys_clk);
         stall_en <= 1'b0;                      // Drain what is left
         repeat (2) @(negedge sys_clk);
         while (rr_access) @(negedge sys_clk);
         repeat (4) @(posedge sys_clk);
         check_count({row_name[r], " responses"}, row_count[r], rx_q.size());
         check_count({row_name[r], " done pulses"}, done_before + 1, done_count);
         for (i = 0; i < rx_q.size() && i < row_count[r]; i++) begin
            rx    = rx_q[i];
            tname = $sformatf("%s resp %0d", row_name[r], i);
            check_data(tname, ref_mem[i], rx[emesh_pkg::PKT_DATA_LSB +: emesh_pkg::DW]);
            check_packet(tname, expect_response(row_dst[r], i, ref_mem[i]), rx);
         end
         for (i = 0; i < emesh_pkg::N_TRANS; i++) begin // Own ID writes leave words alone
            tname = $sformatf("%s mem %0d", row_name[r], i);
            check_data(tname, ref_mem[i], uut.u_memory.mem[i]);
         end
      end
      $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* sources.f */
emesh_pkg.sv
egen_fsm.sv
egen_counter.sv
egen_datapath.sv
emesh_memory.sv
emesh_example.sv
tb_emesh_example.sv

/* Bender.yml */
package:
  name: emesh_example

sources:
  - emesh_pkg.sv
  - egen_fsm.sv
  - egen_counter.sv
  - egen_datapath.sv
  - emesh_memory.sv
  - emesh_example.sv
  - target: test
    files:
      - tb_emesh_example.sv

dependencies: {}

export_include_dirs: []
